//--- verilog/board_pkg.sv
// Board level types and constants
// Status word field positions, game reset length, config widths
`default_nettype none

package board_pkg;

    typedef logic [31:0] status_t;   // OSD menu status word
    typedef logic [6:0]  core_mod_t; // Core mode flags
    typedef logic [7:0]  rst_cnt_t;  // Game reset stretch count
    typedef logic [3:0]  gfx_mask_t; // One enable per graphics layer

    // Cycles game_rst is held once every reset cause is gone
    localparam rst_cnt_t GAME_RST_CYCLES = 8'd255;

    // Status word bit positions
    localparam int ST_NO_ROTATE = 2;  // Keep vertical games unrotated
    localparam int ST_TEST      = 9;
    localparam int ST_FXLEVEL   = 10; // Lower bit of a 2-bit field
    localparam int ST_FLIP      = 12;
    localparam int ST_NO_FM     = 13;
    localparam int ST_NO_PSG    = 14;
    localparam int ST_OSD_PAUSE = 16;

    // Core mode bit positions
    localparam int CM_VERTICAL = 0;
    localparam int CM_4WAY     = 1;

endpackage

`default_nettype wire

//--- verilog/input_pkg.sv
// Player input types and constants
// Joystick widths, button positions, polarity and 4-way direction enum
`default_nettype none

package input_pkg;

    // Raw board joystick, active high
    // Bit 0 right, 1 left, 2 down, 3 up, buttons from bit 4
    typedef logic [15:0] board_joy_t;
    typedef logic [9:0]  game_joy_t;    // Joystick as the game sees it
    typedef logic [3:0]  dir4_t;        // Direction bits only
    typedef logic [3:0]  player_mask_t; // One bit per player

    // Direction remembered by the 4-way filter
    typedef enum logic [2:0] {
        DIR_NONE,
        DIR_RIGHT,
        DIR_LEFT,
        DIR_DOWN,
        DIR_UP
    } dir_e;

    // Fixed for two buttons per player
    localparam int START_BIT = 6;
    localparam int COIN_BIT  = 7;
    localparam int PAUSE_BIT = 8;

    localparam bit GAME_INPUTS_ACTIVE_LOW = 1'b1;

endpackage

`default_nettype wire

//--- verilog/board_cfg_if.sv
// Decoded board configuration bus
`timescale 1ns/1ps
`default_nettype none

interface board_cfg_if;

    logic rot_control; // Vertical game shown rotated
    logic en4way;      // 4-way joystick filter on
    logic dip_flip;
    logic osd_pause;   // Single cycle pulse

    modport cfg_src   (output rot_control, en4way, dip_flip, osd_pause);
    modport cfg_joy   (input rot_control, en4way);
    modport cfg_pause (input osd_pause);
    modport cfg_rst   (input dip_flip);

endinterface

`default_nettype wire

//--- verilog/dip_decode.sv
// Configuration registers
// Decodes status word and core mode into DIP and rotation settings
`timescale 1ns/1ps
`default_nettype none

module dip_decode (
    input  logic                 clk_sys,
    input  logic                 rst,
    input  board_pkg::status_t   status,
    input  board_pkg::core_mod_t core_mod,
    board_cfg_if.cfg_src         cfg,
    output logic [1:0]           rotate,
    output logic                 enable_fm,
    output logic                 enable_psg,
    output logic                 dip_test,
    output logic                 dip_flip,
    output logic [1:0]           dip_fxlevel
);

    import board_pkg::*;

    status_t   status_r;
    core_mod_t core_mod_r;
    logic      osd_last;  // Registered pause bit, one cycle older
    logic      osd_pulse;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            status_r   <= '0;
            core_mod_r <= '0;
            osd_last   <= 1'b0;
            osd_pulse  <= 1'b0;
        end else begin
            status_r   <= status;
            core_mod_r <= core_mod;
            osd_last   <= status_r[ST_OSD_PAUSE];
            osd_pulse  <= status_r[ST_OSD_PAUSE] & ~osd_last; // Rising edge only
        end
    end

    // Vertical game rotated unless the menu says otherwise
    assign cfg.rot_control = core_mod_r[CM_VERTICAL] & ~status_r[ST_NO_ROTATE];
    assign cfg.en4way      = core_mod_r[CM_4WAY];
    assign cfg.dip_flip    = status_r[ST_FLIP];
    assign cfg.osd_pause   = osd_pulse;

    assign dip_flip    = status_r[ST_FLIP];
    assign rotate      = {status_r[ST_FLIP], cfg.rot_control};
    assign enable_fm   = ~status_r[ST_NO_FM];
    assign enable_psg  = ~status_r[ST_NO_PSG];
    assign dip_test    = status_r[ST_TEST];
    assign dip_fxlevel = status_r[ST_FXLEVEL +: 2];

endmodule

`default_nettype wire

//--- verilog/reset_gen.sv
// Game reset stretcher
// Restarts on system reset, requests, downloads, reset key and flip change
`timescale 1ns/1ps
`default_nettype none

module reset_gen (
    input  logic         clk_sys,
    input  logic         rst,
    input  logic         rst_req,
    input  logic         downloading,
    input  logic         key_reset,
    board_cfg_if.cfg_rst cfg,
    output logic         game_rst
);

    import board_pkg::*;

    logic     key_last;
    logic     flip_last;
    logic     key_rise;
    logic     flip_change;
    logic     cause;
    rst_cnt_t cnt;

    // Key and flip values from the previous cycle
    always_ff @(posedge clk_sys) begin
        key_last  <= key_reset;
        flip_last <= cfg.dip_flip;
    end

    assign key_rise    = key_reset & ~key_last;
    assign flip_change = cfg.dip_flip != flip_last;
    assign cause       = rst | rst_req | downloading | key_rise | flip_change;

    always_ff @(posedge clk_sys) begin
        if (cause) begin
            cnt      <= '0; // Held at zero while any cause lasts
            game_rst <= 1'b1;
        end else begin
            if (cnt != GAME_RST_CYCLES) cnt <= rst_cnt_t'(cnt + 1'b1); // Stops at the end
            game_rst <= cnt != GAME_RST_CYCLES;
        end
    end

    // System reset always reaches the game
    a_rst_to_game: assert property (@(posedge clk_sys) rst |=> game_rst);

endmodule

`default_nettype wire

//--- verilog/joy_4way.sv
// 4-way joystick filter for one player
`timescale 1ns/1ps
`default_nettype none

module joy_4way (
    input  logic             clk_sys,
    input  logic             rst,
    input  logic             enable,
    input  input_pkg::dir4_t dir_in,
    output input_pkg::dir4_t dir_out
);

    import input_pkg::*;

    dir_e  last_dir;  // Last direction let through
    dir4_t last_mask;
    dir4_t lowest;
    dir4_t pick;

    function automatic dir4_t dir_mask(dir_e d);
        case (d)
            DIR_RIGHT: return 4'b0001;
            DIR_LEFT:  return 4'b0010;
            DIR_DOWN:  return 4'b0100;
            DIR_UP:    return 4'b1000;
            default:   return 4'b0000;
        endcase
    endfunction

    function automatic dir_e dir_code(dir4_t m);
        case (m)
            4'b0001: return DIR_RIGHT;
            4'b0010: return DIR_LEFT;
            4'b0100: return DIR_DOWN;
            4'b1000: return DIR_UP;
            default: return DIR_NONE;
        endcase
    endfunction

    assign last_mask = dir_mask(last_dir);
    assign lowest    = dir_in & (~dir_in + 4'd1); // Lowest pressed bit
    // Keep the old direction while it is still held
    assign pick      = |(dir_in & last_mask) ? last_mask : lowest;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            last_dir <= DIR_NONE;
            dir_out  <= '0;
        end else if (!enable) begin
            dir_out <= dir_in; // Plain 8-way pass
        end else begin
            dir_out <= pick;
            if (|dir_in) last_dir <= dir_code(pick);
        end
    end

    a_one_dir: assert property (@(posedge clk_sys) disable iff (rst)
        enable |=> $onehot0(dir_out));

endmodule

`default_nettype wire

//--- verilog/joy_condition.sv
// Joystick conditioning for four players
// Register, key merge, rotation, polarity, coin/start/service gathering
`timescale 1ns/1ps
`default_nettype none

module joy_condition (
    input  logic                    clk_sys,
    input  logic                    rst,
    board_cfg_if.cfg_joy            cfg,
    input  input_pkg::board_joy_t   board_joystick1,
    input  input_pkg::board_joy_t   board_joystick2,
    input  input_pkg::board_joy_t   board_joystick3,
    input  input_pkg::board_joy_t   board_joystick4,
    input  input_pkg::game_joy_t    key_joy1,
    input  input_pkg::game_joy_t    key_joy2,
    input  input_pkg::game_joy_t    key_joy3,
    input  input_pkg::player_mask_t key_start,
    input  input_pkg::player_mask_t key_coin,
    input  logic                    key_service,
    output input_pkg::game_joy_t    game_joystick1,
    output input_pkg::game_joy_t    game_joystick2,
    output input_pkg::game_joy_t    game_joystick3,
    output input_pkg::game_joy_t    game_joystick4,
    output input_pkg::player_mask_t game_coin,
    output input_pkg::player_mask_t game_start,
    output logic                    game_service,
    output logic                    joy_pause
);

    import input_pkg::*;

    board_joy_t   board_joy [4];
    game_joy_t    key_joy   [4];
    dir4_t        dir_f     [4]; // Filtered directions, stage 1
    logic [15:4]  btn_r     [4];
    game_joy_t    key_r     [4];
    board_joy_t   joy_sync  [4];
    game_joy_t    joy_out   [4];
    player_mask_t coin_w, start_w;
    player_mask_t key_coin_r, key_start_r;

    // Directions move to up, down, right, left order for vertical games
    function automatic game_joy_t rotate_joy(game_joy_t j, logic rot);
        return rot ? {j[9:4], j[0], j[1], j[3], j[2]} : j;
    endfunction

    assign board_joy[0] = board_joystick1;
    assign board_joy[1] = board_joystick2;
    assign board_joy[2] = board_joystick3;
    assign board_joy[3] = board_joystick4;
    assign key_joy[0]   = key_joy1;
    assign key_joy[1]   = key_joy2;
    assign key_joy[2]   = key_joy3;
    assign key_joy[3]   = '0;       // No keys for player 4

    generate
        for (genvar p = 0; p < 4; p++) begin : gen_player
            joy_4way u_4way (
                .clk_sys ( clk_sys           ),
                .rst     ( rst               ),
                .enable  ( cfg.en4way        ),
                .dir_in  ( board_joy[p][3:0] ),
                .dir_out ( dir_f[p]          )
            );
            assign joy_sync[p] = {btn_r[p], dir_f[p]};
            assign coin_w[p]   = joy_sync[p][COIN_BIT];
            assign start_w[p]  = joy_sync[p][START_BIT];
        end
    endgenerate

    assign joy_pause = joy_sync[0][PAUSE_BIT] | joy_sync[1][PAUSE_BIT];

    // Stage 1, beside the 4-way filter registers
    always_ff @(posedge clk_sys) begin
        for (int i = 0; i < 4; i++) begin
            btn_r[i] <= board_joy[i][15:4];
            key_r[i] <= key_joy[i];
        end
        key_coin_r  <= key_coin;
        key_start_r <= key_start;
    end

    // Stage 2, game side outputs
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) joy_out[i] <= {10{GAME_INPUTS_ACTIVE_LOW}};
            game_coin    <= {4{GAME_INPUTS_ACTIVE_LOW}};
            game_start   <= {4{GAME_INPUTS_ACTIVE_LOW}};
            game_service <= GAME_INPUTS_ACTIVE_LOW;
        end else begin
            for (int i = 0; i < 4; i++) begin
                joy_out[i] <= rotate_joy(joy_sync[i][9:0] | key_r[i], cfg.rot_control)
                              ^ {10{GAME_INPUTS_ACTIVE_LOW}};
            end
            game_coin    <= (coin_w | key_coin_r) ^ {4{GAME_INPUTS_ACTIVE_LOW}};
            game_start   <= (start_w | key_start_r) ^ {4{GAME_INPUTS_ACTIVE_LOW}};
            game_service <= key_service ^ GAME_INPUTS_ACTIVE_LOW; // Single stage
        end
    end

    assign game_joystick1 = joy_out[0];
    assign game_joystick2 = joy_out[1];
    assign game_joystick3 = joy_out[2];
    assign game_joystick4 = joy_out[3];

endmodule

`default_nettype wire

//--- verilog/user_toggles.sv
// Pause toggle and graphics layer enables
`timescale 1ns/1ps
`default_nettype none

module user_toggles (
    input  logic                 clk_sys,
    input  logic                 rst,
    input  logic                 downloading,
    input  logic                 key_pause,
    input  logic                 joy_pause,
    input  board_pkg::gfx_mask_t key_gfx,
    board_cfg_if.cfg_pause       cfg,
    output logic                 dip_pause,
    output board_pkg::gfx_mask_t gfx_en
);

    import board_pkg::*;

    logic      game_pause;
    logic      key_pause_last;
    logic      joy_pause_last;
    gfx_mask_t gfx_last;
    logic      pause_hit;

    always_ff @(posedge clk_sys) begin
        key_pause_last <= key_pause;
        joy_pause_last <= joy_pause;
        gfx_last       <= key_gfx;
    end

    // Any of the three pause sources flips the state
    assign pause_hit = (key_pause & ~key_pause_last) | (joy_pause & ~joy_pause_last)
                     | cfg.osd_pause;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_pause <= 1'b0;
            gfx_en     <= '1;   // All layers shown
        end else begin
            if (downloading) game_pause <= 1'b0;
            else if (pause_hit) game_pause <= ~game_pause;
            gfx_en <= gfx_en ^ (key_gfx & ~gfx_last); // Toggle per key press
        end
    end

    assign dip_pause = ~game_pause; // Game expects it active low

    a_no_pause_on_load: assert property (@(posedge clk_sys) disable iff (rst)
        downloading |=> !game_pause);

endmodule

`default_nettype wire

//--- verilog/board_top.sv
// Arcade board wrapper, input and reset section
// Config decode, game reset, joystick conditioning and user toggles
`timescale 1ns/1ps
`default_nettype none

module board_top (
    input  logic                    clk_sys,
    input  logic                    rst,
    input  logic                    rst_req,
    input  logic                    downloading,
    input  board_pkg::core_mod_t    core_mod,
    input  board_pkg::status_t      status,
    // Board joysticks
    input  input_pkg::board_joy_t   board_joystick1,
    input  input_pkg::board_joy_t   board_joystick2,
    input  input_pkg::board_joy_t   board_joystick3,
    input  input_pkg::board_joy_t   board_joystick4,
    // Decoded keyboard levels
    input  input_pkg::game_joy_t    key_joy1,
    input  input_pkg::game_joy_t    key_joy2,
    input  input_pkg::game_joy_t    key_joy3,
    input  input_pkg::player_mask_t key_start,
    input  input_pkg::player_mask_t key_coin,
    input  logic                    key_reset,
    input  logic                    key_pause,
    input  logic                    key_service,
    input  board_pkg::gfx_mask_t    key_gfx,
    // To the game
    output logic                    game_rst,
    output input_pkg::game_joy_t    game_joystick1,
    output input_pkg::game_joy_t    game_joystick2,
    output input_pkg::game_joy_t    game_joystick3,
    output input_pkg::game_joy_t    game_joystick4,
    output input_pkg::player_mask_t game_coin,
    output input_pkg::player_mask_t game_start,
    output logic                    game_service,
    output logic [1:0]              rotate,
    output logic                    enable_fm,
    output logic                    enable_psg,
    output logic                    dip_test,
    output logic                    dip_pause,
    output logic                    dip_flip,
    output logic [1:0]              dip_fxlevel,
    output board_pkg::gfx_mask_t    gfx_en
);

    board_cfg_if cfg_bus ();

    logic joy_pause; // Pause button from players 1 and 2

    dip_decode u_dip (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .status      ( status      ),
        .core_mod    ( core_mod    ),
        .cfg         ( cfg_bus     ),
        .rotate      ( rotate      ),
        .enable_fm   ( enable_fm   ),
        .enable_psg  ( enable_psg  ),
        .dip_test    ( dip_test    ),
        .dip_flip    ( dip_flip    ),
        .dip_fxlevel ( dip_fxlevel )
    );

    reset_gen u_rst (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .rst_req     ( rst_req     ),
        .downloading ( downloading ),
        .key_reset   ( key_reset   ),
        .cfg         ( cfg_bus     ),
        .game_rst    ( game_rst    )
    );

    joy_condition u_joy (
        .clk_sys         ( clk_sys         ),
        .rst             ( rst             ),
        .cfg             ( cfg_bus         ),
        .board_joystick1 ( board_joystick1 ),
        .board_joystick2 ( board_joystick2 ),
        .board_joystick3 ( board_joystick3 ),
        .board_joystick4 ( board_joystick4 ),
        .key_joy1        ( key_joy1        ),
        .key_joy2        ( key_joy2        ),
        .key_joy3        ( key_joy3        ),
        .key_start       ( key_start       ),
        .key_coin        ( key_coin        ),
        .key_service     ( key_service     ),
        .game_joystick1  ( game_joystick1  ),
        .game_joystick2  ( game_joystick2  ),
        .game_joystick3  ( game_joystick3  ),
        .game_joystick4  ( game_joystick4  ),
        .game_coin       ( game_coin       ),
        .game_start      ( game_start      ),
        .game_service    ( game_service    ),
        .joy_pause       ( joy_pause       )
    );

    user_toggles u_toggles (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .key_pause   ( key_pause   ),
        .joy_pause   ( joy_pause   ),
        .key_gfx     ( key_gfx     ),
        .cfg         ( cfg_bus     ),
        .dip_pause   ( dip_pause   ),
        .gfx_en      ( gfx_en      )
    );

endmodule

`default_nettype wire

//--- test/tb_model.svh
// Cycle model of the board input section
// Reset stretch, 4-way memory, joystick stages, toggles and DIP decode
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

    // Registered configuration
    status_t      m_status_r = '0;
    core_mod_t    m_core_r   = '0;
    logic         m_osd_last  = 1'b0;
    logic         m_osd_pulse = 1'b0;
    // Reset stretch
    logic         m_key_last  = 1'b0;
    logic         m_flip_last = 1'b0;
    int           m_quiet     = 0;  // Edges since the last cause
    // Joystick stage 1, directions already filtered
    board_joy_t   m_sync  [4];
    game_joy_t    m_key_r [4];
    player_mask_t m_kcoin_r;
    player_mask_t m_kstart_r;
    dir_e         m_last  [4];
    // Toggles
    logic         m_kp_last;
    logic         m_jp_last;
    gfx_mask_t    m_gfx_last;
    logic         m_pause;
    // Expected outputs
    logic         m_game_rst;
    game_joy_t    m_out [4];
    player_mask_t m_coin;
    player_mask_t m_start;
    logic         m_service;
    gfx_mask_t    m_gfx;
    logic [1:0]   m_rotate;
    logic [1:0]   m_fxlevel;
    logic [3:0]   m_dips;     // enable_fm, enable_psg, dip_test, dip_flip

    function automatic int lowest_index(input dir4_t d);
        for (int b = 0; b < 4; b++) begin
            if (d[b]) return b;
        end
        return 0;
    endfunction

    function automatic game_joy_t rotated(input game_joy_t j);
        game_joy_t r;
        r    = j;
        r[3] = j[0]; // Right becomes up
        r[2] = j[1];
        r[1] = j[3];
        r[0] = j[2];
        return r;
    endfunction

    // Remembered direction rule for one player
    task automatic step_4way(input int p, input logic en4, input dir4_t din);
        dir4_t held;
        int    idx;
        held = (m_last[p] == DIR_NONE) ? dir4_t'(0) : dir4_t'(1 << (int'(m_last[p]) - 1));
        if (rst) begin
            m_sync[p][3:0] = '0;
            m_last[p]      = DIR_NONE;
        end else if (!en4) begin
            m_sync[p][3:0] = din;
        end else if (din == '0) begin
            m_sync[p][3:0] = '0;            // Memory kept
        end else if ((din & held) != '0) begin
            m_sync[p][3:0] = held;
        end else begin
            idx            = lowest_index(din);
            m_sync[p][3:0] = dir4_t'(1 << idx);
            m_last[p]      = dir_e'(idx + 1);
        end
    endtask

    // One rising edge of clk_sys, inputs as sampled at that edge
    task automatic model_step();
        logic         rot;
        logic         en4;
        logic         flip;
        logic         jp;
        logic         cause;
        logic         hit;
        game_joy_t    j;
        player_mask_t coin_raw;
        player_mask_t start_raw;
        rot   = m_core_r[CM_VERTICAL] & ~m_status_r[ST_NO_ROTATE];
        en4   = m_core_r[CM_4WAY];
        flip  = m_status_r[ST_FLIP];
        jp    = m_sync[0][PAUSE_BIT] | m_sync[1][PAUSE_BIT];
        cause = rst | rst_req | downloading | (key_reset & ~m_key_last) | (flip != m_flip_last);
        hit   = (key_pause & ~m_kp_last) | (jp & ~m_jp_last) | m_osd_pulse;

        // High for GAME_RST_CYCLES plus 1 edges after the last cause
        if (cause) m_quiet = 0;
        else if (m_quiet <= int'(GAME_RST_CYCLES)) m_quiet++;
        m_game_rst  = m_quiet <= int'(GAME_RST_CYCLES);
        m_key_last  = key_reset;
        m_flip_last = flip;

        // Output stage, fed by the old stage 1
        coin_raw  = '0;
        start_raw = '0;
        for (int p = 0; p < 4; p++) begin
            j = rst ? game_joy_t'(0) : (m_sync[p][9:0] | m_key_r[p]);
            if (rot && !rst) j = rotated(j);
            m_out[p] = GAME_INPUTS_ACTIVE_LOW ? ~j : j;
            if (!rst) begin
                coin_raw[p]  = m_sync[p][COIN_BIT] | m_kcoin_r[p];
                start_raw[p] = m_sync[p][START_BIT] | m_kstart_r[p];
            end
        end
        m_coin    = GAME_INPUTS_ACTIVE_LOW ? ~coin_raw : coin_raw;
        m_start   = GAME_INPUTS_ACTIVE_LOW ? ~start_raw : start_raw;
        m_service = (rst ? 1'b0 : key_service) ^ GAME_INPUTS_ACTIVE_LOW;

        for (int p = 0; p < 4; p++) begin
            step_4way(p, en4, board_joy[p][3:0]);
            m_sync[p][15:4] = board_joy[p][15:4];
            if (p < 3) m_key_r[p] = key_joy[p];
            else m_key_r[p] = '0;       // Player 4 has no keys
        end
        m_kcoin_r  = key_coin;
        m_kstart_r = key_start;

        if (rst) begin
            m_pause = 1'b0;
            m_gfx   = '1;
        end else begin
            if (downloading) m_pause = 1'b0;
            else if (hit) m_pause = ~m_pause;
            for (int b = 0; b < 4; b++) begin
                if (key_gfx[b] && !m_gfx_last[b]) m_gfx[b] = ~m_gfx[b];
            end
        end
        m_kp_last  = key_pause;
        m_jp_last  = jp;
        m_gfx_last = key_gfx;

        m_osd_pulse = rst ? 1'b0 : (m_status_r[ST_OSD_PAUSE] & ~m_osd_last);
        m_osd_last  = rst ? 1'b0 : m_status_r[ST_OSD_PAUSE];
        m_status_r  = rst ? status_t'(0) : status;
        m_core_r    = rst ? core_mod_t'(0) : core_mod;

        m_rotate  = {m_status_r[ST_FLIP], m_core_r[CM_VERTICAL] & ~m_status_r[ST_NO_ROTATE]};
        m_fxlevel = m_status_r[ST_FXLEVEL +: 2];
        m_dips    = {~m_status_r[ST_NO_FM], ~m_status_r[ST_NO_PSG],
                     m_status_r[ST_TEST], m_status_r[ST_FLIP]};
    endtask

`endif

//--- test/tb_board.sv
// Testbench for the board input and reset section
// Clock, reset, random stimulus per phase, compare tasks and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_board;

    import board_pkg::*;
    import input_pkg::*;

    localparam int CLK_HALF      = 2;
    localparam int DRIVE_DELAY   = 1;   // After the rising edge
    localparam int RST_CYCLES    = 16;
    localparam int STRETCH_PHASE = 300;
    localparam int RAND_PHASE    = 500;
    localparam int END_PHASE     = 200;
    localparam int TIMEOUT_CYCLES =
        2 * (RST_CYCLES + STRETCH_PHASE + 4 * RAND_PHASE + END_PHASE);

    logic         clk_sys = 1'b0;
    logic         rst;
    logic         rst_req;
    logic         downloading;
    core_mod_t    core_mod;
    status_t      status;
    board_joy_t   board_joy [4];
    game_joy_t    key_joy   [3];
    player_mask_t key_start;
    player_mask_t key_coin;
    logic         key_reset;
    logic         key_pause;
    logic         key_service;
    gfx_mask_t    key_gfx;

    logic         game_rst;
    game_joy_t    game_joy [4];
    player_mask_t game_coin;
    player_mask_t game_start;
    logic         game_service;
    logic [1:0]   rotate;
    logic         enable_fm;
    logic         enable_psg;
    logic         dip_test;
    logic         dip_pause;
    logic         dip_flip;
    logic [1:0]   dip_fxlevel;
    gfx_mask_t    gfx_en;

    integer       seed = 32'hbc11;
    int           cycle_count = 0;
    logic         flip_hold;       // ST_FLIP outside the DIP phase

    `include "tb_model.svh"

    board_top uut (
        .clk_sys         ( clk_sys      ),
        .rst             ( rst          ),
        .rst_req         ( rst_req      ),
        .downloading     ( downloading  ),
        .core_mod        ( core_mod     ),
        .status          ( status       ),
        .board_joystick1 ( board_joy[0] ),
        .board_joystick2 ( board_joy[1] ),
        .board_joystick3 ( board_joy[2] ),
        .board_joystick4 ( board_joy[3] ),
        .key_joy1        ( key_joy[0]   ),
        .key_joy2        ( key_joy[1]   ),
        .key_joy3        ( key_joy[2]   ),
        .key_start       ( key_start    ),
        .key_coin        ( key_coin     ),
        .key_reset       ( key_reset    ),
        .key_pause       ( key_pause    ),
        .key_service     ( key_service  ),
        .key_gfx         ( key_gfx      ),
        .game_rst        ( game_rst     ),
        .game_joystick1  ( game_joy[0]  ),
        .game_joystick2  ( game_joy[1]  ),
        .game_joystick3  ( game_joy[2]  ),
        .game_joystick4  ( game_joy[3]  ),
        .game_coin       ( game_coin    ),
        .game_start      ( game_start   ),
        .game_service    ( game_service ),
        .rotate          ( rotate       ),
        .enable_fm       ( enable_fm    ),
        .enable_psg      ( enable_psg   ),
        .dip_test        ( dip_test     ),
        .dip_pause       ( dip_pause    ),
        .dip_flip        ( dip_flip     ),
        .dip_fxlevel     ( dip_fxlevel  ),
        .gfx_en          ( gfx_en       )
    );

    always #CLK_HALF clk_sys = ~clk_sys;

    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_joy(input string name, input game_joy_t exp, input game_joy_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_mask(input string name, input player_mask_t exp,
                              input player_mask_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_gfx(input string name, input gfx_mask_t exp, input gfx_mask_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    // Rotation, effect level and the single DIP bits together
    task automatic check_status_out(input string name,
                                    input logic [1:0] exp_rot, input logic [1:0] exp_fx,
                                    input logic [3:0] exp_dips,
                                    input logic [1:0] act_rot, input logic [1:0] act_fx,
                                    input logic [3:0] act_dips);
        if ({act_rot, act_fx, act_dips} !== {exp_rot, exp_fx, exp_dips}) begin
            $display("CHECK FAILED %s: expected rotate %b fx %b dips %b, actual %b %b %b",
                     name, exp_rot, exp_fx, exp_dips, act_rot, act_fx, act_dips);
            abort_run();
        end
    endtask

    task automatic compare_outputs(input string name);
        check_bit({name, " game_rst"}, m_game_rst, game_rst);
        for (int p = 0; p < 4; p++) begin
            check_joy($sformatf("%s game_joystick%0d", name, p + 1), m_out[p], game_joy[p]);
        end
        check_mask({name, " game_coin"}, m_coin, game_coin);
        check_mask({name, " game_start"}, m_start, game_start);
        check_bit({name, " game_service"}, m_service, game_service);
        check_bit({name, " dip_pause"}, ~m_pause, dip_pause);
        check_gfx({name, " gfx_en"}, m_gfx, gfx_en);
        check_status_out({name, " dip outputs"}, m_rotate, m_fxlevel, m_dips,
                         rotate, dip_fxlevel, {enable_fm, enable_psg, dip_test, dip_flip});
    endtask

    // Model and DUT take the same edge, outputs read once settled
    task automatic run_cycle(input string name);
        @(posedge clk_sys);
        model_step();
        #DRIVE_DELAY;
        compare_outputs(name);
    endtask

    function automatic dir4_t pressed_dirs(input game_joy_t j);
        return GAME_INPUTS_ACTIVE_LOW ? ~j[3:0] : j[3:0];
    endfunction

    function automatic string phase_name(input int ph);
        case (ph)
            1:       return "joy_plain";
            2:       return "joy_rotate";
            3:       return "joy_4way";
            default: return "dip_decode";
        endcase
    endfunction

    task automatic init_inputs();
        rst         = 1'b1;
        rst_req     = 1'b0;
        downloading = 1'b0;
        core_mod    = '0;
        status      = '0;
        key_start   = '0;
        key_coin    = '0;
        key_reset   = 1'b0;
        key_pause   = 1'b0;
        key_service = 1'b0;
        key_gfx     = '0;
        flip_hold   = 1'b0;
        for (int p = 0; p < 4; p++) board_joy[p] = '0;
        for (int p = 0; p < 3; p++) key_joy[p] = '0;
    endtask

    task automatic drive_random(input int ph);
        logic [31:0] r;
        for (int p = 0; p < 4; p++) begin
            r = $random(seed);
            board_joy[p] = r[15:0];
        end
        for (int p = 0; p < 3; p++) begin
            r = $random(seed) & $random(seed); // Sparse key presses
            key_joy[p] = r[9:0];
            if (ph == 3) key_joy[p][3:0] = '0; // Keys bypass the 4-way filter
        end
        r = $random(seed) & $random(seed);
        key_start   = r[3:0];
        key_coin    = r[7:4];
        r = $random(seed);
        key_pause   = r[0];
        key_service = r[1];
        key_gfx     = r[5:2];
        rst_req     = 1'b0;
        key_reset   = 1'b0;
        downloading = 1'b0;
        r = $random(seed);
        case (ph)
            1:       core_mod = '0;
            2:       core_mod = 7'd1;
            3:       core_mod = {5'b0, 1'b1, r[0]};
            default: core_mod = r[6:0];
        endcase
        status = $random(seed);
        if (ph != 4) status[ST_FLIP] = flip_hold;
    endtask

    initial begin
        init_inputs();
        for (int i = 0; i < RST_CYCLES; i++) begin
            run_cycle("system_reset");
        end
        rst = 1'b0;

        // Full stretch first, then each cause restarts it
        for (int i = 0; i < STRETCH_PHASE; i++) begin
            run_cycle("reset_stretch");
            key_reset   = (i == 260);
            rst_req     = (i == 270);
            downloading = (i >= 280 && i < 282);
            if (i == 290) flip_hold = 1'b1;
            status[ST_FLIP] = flip_hold;
        end

        for (int ph = 1; ph <= 4; ph++) begin
            for (int i = 0; i < RAND_PHASE; i++) begin
                run_cycle(phase_name(ph));
                if (ph == 3 && i >= 4) begin
                    for (int p = 0; p < 4; p++) begin
                        check_bit($sformatf("joy_4way single dir %0d", p + 1), 1'b1,
                                  $onehot0(pressed_dirs(game_joy[p])));
                    end
                end
                drive_random(ph);
            end
        end

        for (int i = 0; i < END_PHASE; i++) begin
            run_cycle("pause_download");
            if (downloading) check_bit("pause_download dip_pause", 1'b1, dip_pause);
            drive_random(5);
            downloading = (i < 20) || (i >= 100 && i < 110);
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+test
verilog/board_pkg.sv
verilog/input_pkg.sv
verilog/board_cfg_if.sv
verilog/dip_decode.sv
verilog/reset_gen.sv
verilog/joy_4way.sv
verilog/joy_condition.sv
verilog/user_toggles.sv
verilog/board_top.sv
test/tb_board.sv

//--- run_sim.sh
#!/bin/bash
# Compile and run tb_board with Verilator, pass or fail taken from the log

cd "$(dirname "$0")" || exit 1
mkdir -p build

verilator --binary --assert --top-module tb_board -f project.f -Mdir build -o tb_board \
    && ./build/tb_board | tee build/sim.log \
    || { echo "Build or simulation failed"; exit 1; }

grep -q "Finished with no errors" build/sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
